// File: alu.sv
module alu #(
	parameter int dataWidth = 32
) (
	input cpuPkg::opcodeT op,
	input logic [dataWidth-1:0] a, // y register
	input logic [dataWidth-1:0] b, // bus
	output logic [dataWidth-1:0] result,
	output logic illegalOp
);

	always_comb begin
		illegalOp = 1'b0;
		case (op)
			cpuPkg::opAdd: begin
				result = a + b;
			end
			cpuPkg::opSub: begin
				result = a - b;
			end
			cpuPkg::opAnd: begin
				result = a & b;
			end
			cpuPkg::opOr: begin
				result = a | b;
			end
			cpuPkg::opInc: begin
				result = b + 1'b1; // pc + 1
			end
			cpuPkg::opPassB: begin
				result = b;
			end
			default: begin // unsupported opcode
				result = '0;
				illegalOp = 1'b1;
			end
		endcase
	end

endmodule

// File: busCpu.sv
module busCpu #(
	parameter int dataWidth = 32,
	parameter int regCount = 16,
	parameter int memWait = 2
) (
	input logic clk,
	input logic arstN,
	input logic loadEn,
	input logic [3:0] loadAddr,
	input logic [dataWidth-1:0] loadData,
	input logic start,
	input logic [dataWidth-1:0] memData,
	input logic [3:0] peekAddr,
	output logic busy,
	output logic done,
	output logic illegal,
	output logic [dataWidth-1:0] memAddr,
	output logic memRead,
	output logic [dataWidth-1:0] peekData
);

	// timer handshake with the fsm
	cpuPkg::stepT step;
	logic stepClear;
	logic stepAdvance;
	logic waitStart;
	logic waitDone;

	// datapath controls
	cpuPkg::busSrcT busSrc;
	cpuPkg::opcodeT aluOp;
	logic [3:0] regRdAddr;
	logic [3:0] regWrAddr;
	logic regWrEn;
	logic pcLoad;
	logic marLoad;
	logic mdrLoad;
	logic irLoad;
	logic yLoad;
	logic zLoad;

	logic [dataWidth-1:0] bus;
	logic [dataWidth-1:0] y;
	logic [dataWidth-1:0] ir;
	logic [dataWidth-1:0] regRdData;
	logic [dataWidth-1:0] aluResult;
	logic aluIllegal;

	phaseTimer #(.memWait(memWait)) u_phaseTimer (
		.clk(clk), .arstN(arstN),
		.stepClear(stepClear), .stepAdvance(stepAdvance), .waitStart(waitStart),
		.step(step), .waitDone(waitDone)
	);

	controlFsm #(.dataWidth(dataWidth)) u_controlFsm (
		.clk(clk), .arstN(arstN),
		.loadEn(loadEn), .start(start), .loadAddr(loadAddr), .ir(ir),
		.aluIllegal(aluIllegal), .step(step), .waitDone(waitDone),
		.stepClear(stepClear), .stepAdvance(stepAdvance), .waitStart(waitStart),
		.busSrc(busSrc), .regRdAddr(regRdAddr), .regWrAddr(regWrAddr), .regWrEn(regWrEn),
		.pcLoad(pcLoad), .marLoad(marLoad), .mdrLoad(mdrLoad), .irLoad(irLoad),
		.yLoad(yLoad), .zLoad(zLoad), .memRead(memRead), .aluOp(aluOp),
		.busy(busy), .done(done), .illegal(illegal)
	);

	regFile #(.dataWidth(dataWidth), .regCount(regCount)) u_regFile (
		.clk(clk), .arstN(arstN),
		.wrEn(regWrEn), .wrAddr(regWrAddr), .rdAddr(regRdAddr), .peekAddr(peekAddr),
		.wrData(bus), .rdData(regRdData), .peekData(peekData)
	);

	busUnit #(.dataWidth(dataWidth)) u_busUnit (
		.clk(clk), .arstN(arstN), .busSrc(busSrc),
		.regRdData(regRdData), .loadData(loadData), .memData(memData), .aluResult(aluResult),
		.pcLoad(pcLoad), .marLoad(marLoad), .mdrLoad(mdrLoad), .irLoad(irLoad),
		.yLoad(yLoad), .zLoad(zLoad),
		.bus(bus), .y(y), .ir(ir), .mar(memAddr) // mar is the memory address
	);

	alu #(.dataWidth(dataWidth)) u_alu (
		.op(aluOp), .a(y), .b(bus),
		.result(aluResult), .illegalOp(aluIllegal)
	);

endmodule

// File: busUnit.sv
module busUnit #(
	parameter int dataWidth = 32
) (
	input logic clk,
	input logic arstN,
	input cpuPkg::busSrcT busSrc,
	input logic [dataWidth-1:0] regRdData,
	input logic [dataWidth-1:0] loadData,
	input logic [dataWidth-1:0] memData,
	input logic [dataWidth-1:0] aluResult,
	input logic pcLoad,
	input logic marLoad,
	input logic mdrLoad,
	input logic irLoad,
	input logic yLoad,
	input logic zLoad,
	output logic [dataWidth-1:0] bus,
	output logic [dataWidth-1:0] y,
	output logic [dataWidth-1:0] ir,
	output logic [dataWidth-1:0] mar
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] mdr;
	logic [dataWidth-1:0] z;

	// single shared bus
	always_comb begin
		case (busSrc)
			cpuPkg::srcReg: bus = regRdData;
			cpuPkg::srcPc: bus = pc;
			cpuPkg::srcMdr: bus = mdr;
			cpuPkg::srcZ: bus = z;
			cpuPkg::srcLoad: bus = loadData;
			default: bus = '0;
		endcase
	end

	// pc and mar come out of reset at address zero
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= '0;
			mar <= '0;
		end else begin
			if (pcLoad) pc <= bus;
			if (marLoad) mar <= bus; // drives memAddr
		end
	end

	always_ff @(posedge clk) begin
		if (mdrLoad) begin
			mdr <= memData; // straight from memory, not the bus
		end
		if (irLoad) begin
			ir <= bus;
		end
		if (yLoad) begin
			y <= bus;
		end
		if (zLoad) begin
			z <= aluResult;
		end
	end

endmodule

// File: controlFsm.sv
module controlFsm #(
	parameter int dataWidth = 32
) (
	input logic clk,
	input logic arstN,
	input logic loadEn,
	input logic start,
	input logic [3:0] loadAddr,
	input logic [dataWidth-1:0] ir,
	input logic aluIllegal,
	input cpuPkg::stepT step,
	input logic waitDone,
	output logic stepClear,
	output logic stepAdvance,
	output logic waitStart,
	output cpuPkg::busSrcT busSrc,
	output logic [3:0] regRdAddr,
	output logic [3:0] regWrAddr,
	output logic regWrEn,
	output logic pcLoad,
	output logic marLoad,
	output logic mdrLoad,
	output logic irLoad,
	output logic yLoad,
	output logic zLoad,
	output logic memRead,
	output cpuPkg::opcodeT aluOp,
	output logic busy,
	output logic done,
	output logic illegal
);

	typedef enum logic [1:0] {
		stIdle,
		stLoad, // last cycle wrote through the load port
		stRun
	} stateT;

	stateT state;
	stateT stateNext;
	logic illegalQ; // opcode rejected by the alu in T4
	logic [cpuPkg::regFieldW-1:0] ra;
	logic [cpuPkg::regFieldW-1:0] rb;
	logic [cpuPkg::regFieldW-1:0] rc;

	assign ra = ir[cpuPkg::raLsb +: cpuPkg::regFieldW];
	assign rb = ir[cpuPkg::rbLsb +: cpuPkg::regFieldW];
	assign rc = ir[cpuPkg::rcLsb +: cpuPkg::regFieldW];

	always_comb begin
		stateNext = state;
		case (state)
			stIdle, stLoad: begin
				if (loadEn) stateNext = stLoad; // load beats start
				else if (start) stateNext = stRun;
				else stateNext = stIdle;
			end
			stRun: begin
				if (step == cpuPkg::stepT5) stateNext = stIdle;
			end
			default: stateNext = stIdle;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			memRead <= 1'b0;
			illegalQ <= 1'b0;
		end else begin
			state <= stateNext;
			memRead <= (state == stRun) && (step == cpuPkg::stepT0); // first T1 cycle
			if ((state == stRun) && (step == cpuPkg::stepT4)) illegalQ <= aluIllegal;
		end
	end

	assign waitStart = memRead; // wait counts from the read strobe
	assign busy = (state == stRun);

	// step decode into bus select and enables
	always_comb begin
		busSrc = cpuPkg::srcNone;
		regRdAddr = '0;
		regWrAddr = '0;
		regWrEn = 1'b0;
		pcLoad = 1'b0;
		marLoad = 1'b0;
		mdrLoad = 1'b0;
		irLoad = 1'b0;
		yLoad = 1'b0;
		zLoad = 1'b0;
		aluOp = cpuPkg::opPassB;
		stepClear = 1'b0;
		stepAdvance = 1'b0;
		done = 1'b0;
		illegal = 1'b0;
		case (state)
			stIdle, stLoad: begin
				if (loadEn) begin
					busSrc = cpuPkg::srcLoad;
					regWrAddr = loadAddr;
					regWrEn = 1'b1;
				end else if (start) begin
					stepClear = 1'b1; // run begins at T0
				end
			end
			stRun: begin
				case (step)
					cpuPkg::stepT0: begin // pc to mar, z = pc + 1
						busSrc = cpuPkg::srcPc;
						marLoad = 1'b1;
						aluOp = cpuPkg::opInc;
						zLoad = 1'b1;
						stepAdvance = 1'b1;
					end
					cpuPkg::stepT1: begin
						if (memRead) begin // z back to pc
							busSrc = cpuPkg::srcZ;
							pcLoad = 1'b1;
						end
						if (waitDone) begin
							mdrLoad = 1'b1;
							stepAdvance = 1'b1;
						end
					end
					cpuPkg::stepT2: begin
						busSrc = cpuPkg::srcMdr;
						irLoad = 1'b1;
						stepAdvance = 1'b1;
					end
					cpuPkg::stepT3: begin
						regRdAddr = rb;
						busSrc = cpuPkg::srcReg;
						yLoad = 1'b1;
						stepAdvance = 1'b1;
					end
					cpuPkg::stepT4: begin
						regRdAddr = rc;
						busSrc = cpuPkg::srcReg;
						aluOp = cpuPkg::opcodeT'(ir[cpuPkg::opcodeMsb:cpuPkg::opcodeLsb]);
						zLoad = 1'b1;
						stepAdvance = 1'b1;
					end
					cpuPkg::stepT5: begin
						busSrc = cpuPkg::srcZ;
						regWrAddr = ra;
						regWrEn = !illegalQ; // keep registers on a bad opcode
						done = 1'b1;
						illegal = illegalQ;
						stepClear = 1'b1;
					end
					default: stepClear = 1'b1;
				endcase
			end
			default: ;
		endcase
	end

endmodule

// File: cpuPkg.sv
package cpuPkg;

	// instruction opcodes plus two internal alu controls
	typedef enum logic [4:0] {
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opInc = 5'd30, // pc increment in T0, never decoded
		opPassB = 5'd31 // bus straight through
	} opcodeT;

	// who drives the shared bus
	typedef enum logic [2:0] {
		srcNone = 3'd0, // bus reads as zero
		srcReg = 3'd1,
		srcPc = 3'd2,
		srcMdr = 3'd3,
		srcZ = 3'd4,
		srcLoad = 3'd5 // external load port
	} busSrcT;

	// execution steps of one instruction
	typedef enum logic [2:0] {
		stepT0 = 3'd0,
		stepT1 = 3'd1, // stretched by the memory wait
		stepT2 = 3'd2,
		stepT3 = 3'd3,
		stepT4 = 3'd4,
		stepT5 = 3'd5
	} stepT;

	// instruction word layout
	// op[31:27] ra[26:23] rb[22:19] rc[18:15]
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int raLsb = 23;
	localparam int rbLsb = 19;
	localparam int rcLsb = 15;

	localparam int regFieldW = 4; // register field width

endpackage

// File: phaseTimer.sv
module phaseTimer #(
	parameter int memWait = 2
) (
	input logic clk,
	input logic arstN,
	input logic stepClear,
	input logic stepAdvance,
	input logic waitStart,
	output cpuPkg::stepT step,
	output logic waitDone
);

	localparam int cntW = $clog2(memWait + 1);

	logic [cntW-1:0] waitCnt; // cycles left until memory data is valid

	// step register
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			step <= cpuPkg::stepT0;
		end else if (stepClear) begin
			step <= cpuPkg::stepT0;
		end else if (stepAdvance) begin
			step <= cpuPkg::stepT'(step + 3'd1);
		end
	end

	// memory wait down-counter
	// loaded in the read cycle, counts to zero afterwards
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			waitCnt <= '0;
		end else if (waitStart) begin
			waitCnt <= cntW'(memWait);
		end else if (waitCnt != '0) begin
			waitCnt <= waitCnt - 1'b1;
		end
	end

	// last cycle of the wait, mdr may capture
	assign waitDone = (waitCnt == cntW'(1));

endmodule

// File: regFile.sv
module regFile #(
	parameter int dataWidth = 32,
	parameter int regCount = 16
) (
	input logic clk,
	input logic arstN,
	input logic wrEn,
	input logic [3:0] wrAddr,
	input logic [3:0] rdAddr,
	input logic [3:0] peekAddr,
	input logic [dataWidth-1:0] wrData,
	output logic [dataWidth-1:0] rdData,
	output logic [dataWidth-1:0] peekData
);

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && (wrAddr < regCount)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// addresses past regCount read as zero
	assign rdData = (rdAddr < regCount) ? regs[rdAddr] : '0;
	assign peekData = (peekAddr < regCount) ? regs[peekAddr] : '0;

endmodule

// File: tbBusCpu.sv
module tbBusCpu;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int memWait = 2; // dut default
	localparam int runEdges = 5 + memWait; // start edge to done cycle
	localparam int memDepth = 64;
	localparam int numInstr = 23;
	localparam int preloadCycles = 8 + 16 + 6 + 4 + 2 * 20 + 1 + 10 + 2 * numInstr;
	localparam int watchdogCycles = numInstr * (6 + memWait) + preloadCycles + 200;

	logic clk;
	logic arstN;
	logic loadEn;
	logic [3:0] loadAddr;
	logic [31:0] loadData;
	logic start;
	logic [31:0] memData;
	logic [3:0] peekAddr;
	logic busy;
	logic done;
	logic illegal;
	logic [31:0] memAddr;
	logic memRead;
	logic [31:0] peekData;

	logic [31:0] mem [memDepth];
	logic [31:0] regModel [16]; // software copy of the register file
	logic [31:0] pcModel;
	logic [31:0] rngState;
	int mismatchCount;
	int failCount;

	busCpu u_dut (
		.clk(clk), .arstN(arstN),
		.loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData), .start(start),
		.memData(memData), .peekAddr(peekAddr),
		.busy(busy), .done(done), .illegal(illegal),
		.memAddr(memAddr), .memRead(memRead), .peekData(peekData)
	);

	// combinational memory on memAddr
	assign memData = (memAddr < memDepth) ? mem[memAddr] : '0;

	always #2 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic logic [31:0] makeInstr(input logic [4:0] op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [3:0] rc);
		return {op, ra, rb, rc, 15'd0};
	endfunction

	function automatic bit isLegal(input logic [4:0] op);
		return (op == cpuPkg::opAdd) || (op == cpuPkg::opSub) ||
			(op == cpuPkg::opAnd) || (op == cpuPkg::opOr);
	endfunction

	// R[ra] = R[rb] op R[rc]
	function automatic logic [31:0] expectedResult(input logic [4:0] op,
		input logic [31:0] a, input logic [31:0] b);
		case (op)
			cpuPkg::opAdd: return a + b;
			cpuPkg::opSub: return a - b;
			cpuPkg::opAnd: return a & b;
			cpuPkg::opOr: return a | b;
			default: return '0;
		endcase
	endfunction

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			mismatchCount++;
			$display("MISMATCH at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic nextCycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic loadReg(input logic [3:0] addr, input logic [31:0] data);
		loadEn = 1'b1;
		loadAddr = addr;
		loadData = data;
		nextCycle(); // written at this edge
		loadEn = 1'b0;
		regModel[addr] = data;
	endtask

	task automatic checkAllRegs(input string what);
		for (int i = 0; i < 16; i++) begin
			peekAddr = 4'(i);
			#0.1;
			checkEq(peekData, regModel[i], $sformatf("%s, R%0d", what, i));
		end
		nextCycle(); // back on the drive grid
	endtask

	// one instruction from start to the register check
	task automatic runInstr(input logic [31:0] word, input bit poke);
		int edges;
		int reads;
		logic [31:0] readAddr;
		logic [4:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic gotDone;
		logic gotIllegal;
		op = word[31:27];
		ra = word[26:23];
		rb = word[22:19];
		rc = word[18:15];
		mem[pcModel] = word;
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		edges = 0;
		reads = 0;
		readAddr = '0;
		gotDone = 1'b0;
		gotIllegal = 1'b0;
		while (!gotDone && edges < runEdges) begin
			nextCycle();
			edges++;
			checkEq(busy, 1, "busy during run");
			if (memRead) begin
				reads++;
				readAddr = memAddr;
			end
			if (done) begin
				gotDone = 1'b1;
				gotIllegal = illegal;
			end
			if (poke && edges == 2) start = 1'b1; // must be ignored while busy
			if (poke && edges == 3) begin
				start = 1'b0;
				loadEn = 1'b1;
				loadAddr = ra ^ 4'd1;
				loadData = nextRandom();
			end
			if (poke && edges == 4) loadEn = 1'b0;
		end
		if (!gotDone) begin
			failCount++;
			$display("done did not arrive within %0d cycles of start, time %0t", runEdges, $time);
		end else begin
			checkEq(edges, runEdges, "cycles from start to done");
		end
		checkEq(reads, 1, "memory read strobes per instruction");
		checkEq(readAddr, pcModel, "fetch address");
		checkEq(gotIllegal, !isLegal(op), "illegal flag with done");
		if (isLegal(op)) regModel[ra] = expectedResult(op, regModel[rb], regModel[rc]);
		pcModel = pcModel + 1;
		nextCycle(); // destination written at the end of T5
		if (busy) begin
			failCount++;
			$display("busy still high after the run finished, time %0t", $time);
		end
		checkAllRegs($sformatf("after instruction %h", word));
	endtask

	task automatic resetCheck();
		checkEq(busy, 0, "busy after reset");
		checkEq(done, 0, "done after reset");
		checkEq(illegal, 0, "illegal after reset");
		checkEq(memRead, 0, "memRead after reset");
		checkEq(memAddr, 0, "memAddr after reset");
		checkAllRegs("after reset");
	endtask

	task automatic loadPeekTest();
		for (int i = 0; i < 16; i++) begin
			loadReg(4'(i), nextRandom());
		end
		checkAllRegs("load port");
		start = 1'b1; // load wins over start
		loadEn = 1'b1;
		loadAddr = 4'd7;
		loadData = nextRandom();
		regModel[7] = loadData;
		nextCycle();
		start = 1'b0;
		loadEn = 1'b0;
		repeat (3) begin
			nextCycle();
			checkEq(busy, 0, "busy after start together with load");
			checkEq(done, 0, "done after start together with load");
		end
		checkAllRegs("start together with load");
	endtask

	task automatic andTest();
		loadReg(4'd2, 32'h0000_0034);
		loadReg(4'd3, 32'h0000_0045);
		runInstr(32'h2891_8000, 1'b0); // and R1, R2, R3
		peekAddr = 4'd1;
		#0.1;
		checkEq(peekData, 32'h0000_0034 & 32'h0000_0045, "and result in R1");
		nextCycle();
	endtask

	task automatic aluOpsTest();
		logic [31:0] r;
		logic [4:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		for (int i = 0; i < 20; i++) begin
			r = nextRandom();
			case (r % 3)
				0: op = cpuPkg::opAdd;
				1: op = cpuPkg::opSub;
				default: op = cpuPkg::opOr;
			endcase
			r = nextRandom();
			ra = r[3:0];
			rb = r[7:4];
			rc = r[11:8];
			if (i % 5 == 0) ra = rb; // destination also a source
			if (i % 5 == 1) ra = rc;
			loadReg(rb, nextRandom());
			loadReg(rc, nextRandom());
			runInstr(makeInstr(op, ra, rb, rc), 1'b0);
		end
	endtask

	task automatic illegalTest();
		loadReg(4'd1, nextRandom()); // destination nonzero before the bad opcode
		runInstr(makeInstr(5'd12, 4'd1, 4'd2, 4'd3), 1'b0);
	endtask

	// pc advance after the illegal opcode shows in this fetch address
	task automatic busyIgnoreTest();
		int extraDone;
		runInstr(makeInstr(cpuPkg::opAdd, 4'd4, 4'd5, 4'd6), 1'b1);
		extraDone = 0;
		repeat (10) begin
			nextCycle();
			if (done) extraDone++;
			checkEq(busy, 0, "busy after ignored pulses");
		end
		checkEq(extraDone, 0, "extra done pulses");
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		start = 1'b0;
		peekAddr = '0;
		rngState = 32'd73291;
		mismatchCount = 0;
		failCount = 0;
		pcModel = '0;
		for (int i = 0; i < memDepth; i++) begin
			mem[i] = {5'd0, 27'(i)}; // opcode 0 with the address in the low bits
		end
		for (int i = 0; i < 16; i++) begin
			regModel[i] = '0;
		end
		repeat (8) nextCycle();
		arstN = 1'b1;
		resetCheck();
		loadPeekTest();
		andTest();
		aluOpsTest();
		illegalTest();
		busyIgnoreTest();
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (watchdogCycles) @(posedge clk);
		failCount++;
		$display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
		$display("errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// File: vlog.f
cpuPkg.sv
phaseTimer.sv
alu.sv
regFile.sv
busUnit.sv
controlFsm.sv
busCpu.sv
tbBusCpu.sv
